// File: verilog/fsb_axi_cfg.svh
// fsb to axi writer widths and constants

`ifndef FSB_AXI_CFG_SVH
`define FSB_AXI_CFG_SVH

// axi host interface
`define AXI_DATA_W 512
`define AXI_ADDR_W 64
`define BEAT_BYTES 64

// tail pointer beat only carries the low word
`define TAIL_STRB_BYTES 8

// fsb side, four packets per beat
`define FSB_W 80
`define FSB_LANES 4

// config bus
`define CFG_ADDR_W 8
`define CFG_DATA_W 32

`endif

// File: verilog/cfg_regs_pkg.sv
// config register map types

`include "fsb_axi_cfg.svh"

package cfg_regs_pkg;

  typedef logic [`CFG_ADDR_W-1:0] cfg_addr_t;
  typedef logic [`CFG_DATA_W-1:0] cfg_data_t;

  // one-cycle request from the host
  typedef struct packed {
    logic      wr;
    logic      rd;
    cfg_addr_t addr;
    cfg_data_t wdata;
  } cfg_req_t;

  // byte offsets of the registers
  typedef enum logic [`CFG_ADDR_W-1:0] {
    CFG      = 8'h00,
    CNTL     = 8'h08,
    RESET    = 8'h0c,
    WADDR_LO = 8'h20,
    WADDR_HI = 8'h24,
    HEAD     = 8'h28,
    BUF_SIZE = 8'h30
  } reg_offset_e;

  // static settings seen by the writer
  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] base;
    cfg_data_t              buf_size;
    cfg_data_t              head;
    logic                   wvalid_mask;
  } wr_ctrl_t;

  typedef struct packed {
    logic busy;
    logic stop_pend;
    logic bresp_err;
  } wr_status_t;

endpackage

// File: verilog/axi_wr_pkg.sv
// axi write and fsb types

`include "fsb_axi_cfg.svh"

package axi_wr_pkg;

  typedef logic [`AXI_ADDR_W-1:0]   axi_addr_t;
  typedef logic [`AXI_DATA_W-1:0]   axi_data_t;
  typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t;
  typedef logic [`FSB_W-1:0]        fsb_data_t;

  // byte offset inside the ring buffer
  typedef logic [31:0] ring_off_t;

  // ------------------------------------------------
  // channel payloads
  // ------------------------------------------------

  // write address, len is always 0 here
  typedef struct packed {
    axi_addr_t  addr;
    logic [7:0] len;
  } aw_chan_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } w_chan_t;

  // ------------------------------------------------
  // write sequencer states
  // ------------------------------------------------
  typedef enum logic [2:0] {
    WR_IDLE = 3'd0,
    WR_WAIT = 3'd1,
    WR_ADDR = 3'd2,
    WR_DATA = 3'd3,
    WR_RESP = 3'd4,
    WR_STOP = 3'd5
  } wr_state_e;

endpackage

// File: verilog/cfg_reg_decode.sv
// config register decode

module cfg_reg_decode (
  input  logic                    clk,
  input  logic                    sync_rst_n,
  input  cfg_regs_pkg::cfg_req_t   cfg_req_i,
  input  cfg_regs_pkg::wr_status_t status_i,
  output logic                    cfg_ack_o,
  output cfg_regs_pkg::cfg_data_t  cfg_rdata_o,
  output cfg_regs_pkg::wr_ctrl_t   ctrl_o,
  output logic                    go_o,
  output logic                    stop_o,
  output logic                    reset_o
);
  import cfg_regs_pkg::*;

  logic       wr_pend_q;
  logic       rd_pend_q;
  logic       ack_q;
  logic       req_cycle;
  logic       wr_ack;
  cfg_addr_t  addr_q;
  cfg_data_t  wdata_q;
  cfg_data_t  rdata_q;
  wr_ctrl_t   ctrl_q;

  // ------------------------------------------------
  // request stretch and ack
  // ------------------------------------------------

  // cycle between request and ack
  assign req_cycle = (wr_pend_q || rd_pend_q) && !ack_q;

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      wr_pend_q <= 1'b0;
      rd_pend_q <= 1'b0;
      ack_q     <= 1'b0;
    end
    else
    begin
      wr_pend_q <= cfg_req_i.wr || (wr_pend_q && !ack_q);
      rd_pend_q <= cfg_req_i.rd || (rd_pend_q && !ack_q);
      // lands 2 cycles after the request
      ack_q     <= req_cycle;
    end
  end

  // address and data held for the whole access
  always_ff @(posedge clk)
  begin
    if (cfg_req_i.wr || cfg_req_i.rd)
    begin
      addr_q  <= cfg_req_i.addr;
      wdata_q <= cfg_req_i.wdata;
    end
  end

  // ------------------------------------------------
  // register storage
  // ------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      ctrl_q <= '0;
    else if (wr_pend_q && !ack_q)
    begin
      case (addr_q)
        CFG:      ctrl_q.wvalid_mask <= wdata_q[4];
        WADDR_LO: ctrl_q.base[31:0]  <= wdata_q;
        WADDR_HI: ctrl_q.base[63:32] <= wdata_q;
        HEAD:     ctrl_q.head        <= wdata_q;
        BUF_SIZE: ctrl_q.buf_size    <= wdata_q;
        default:  ctrl_q             <= ctrl_q;
      endcase
    end
  end

  // readback, valid in the ack cycle
  always_ff @(posedge clk)
  begin
    if (req_cycle)
    begin
      case (addr_q)
        CFG:      rdata_q <= {27'b0, ctrl_q.wvalid_mask, 4'b0};
        CNTL:     rdata_q <= {28'b0, status_i.bresp_err, 1'b0,
                              status_i.stop_pend, status_i.busy};
        RESET:    rdata_q <= '0;
        WADDR_LO: rdata_q <= ctrl_q.base[31:0];
        WADDR_HI: rdata_q <= ctrl_q.base[63:32];
        HEAD:     rdata_q <= ctrl_q.head;
        BUF_SIZE: rdata_q <= ctrl_q.buf_size;
        default:  rdata_q <= '1;
      endcase
    end
  end

  // ------------------------------------------------
  // control pulses, fired with the ack
  // ------------------------------------------------
  assign wr_ack  = ack_q && wr_pend_q;
  assign go_o    = wr_ack && (addr_q == CNTL) && wdata_q[0];
  assign stop_o  = wr_ack && (addr_q == CNTL) && !wdata_q[0];
  assign reset_o = wr_ack && (addr_q == RESET) && wdata_q[0];

  assign cfg_ack_o   = ack_q;
  assign cfg_rdata_o = rdata_q;
  assign ctrl_o      = ctrl_q;

endmodule

// File: verilog/fsb_beat_packer.sv
// fsb packet to axi beat packer

`include "fsb_axi_cfg.svh"

module fsb_beat_packer (
  input  logic                  clk,
  input  logic                  sync_rst_n,
  input  logic                  fsb_valid_i,
  input  axi_wr_pkg::fsb_data_t fsb_data_i,
  input  logic                  mask_i,
  input  logic                  beat_take_i,
  output logic                  fsb_yumi_o,
  output axi_wr_pkg::axi_data_t beat_o,
  output logic                  beat_valid_o
);
  import axi_wr_pkg::*;

  // 128 bit lane per packet
  localparam int LANE_W = `AXI_DATA_W / `FSB_LANES;

  logic [1:0] lane_q;
  logic       beat_valid_q;
  logic       yumi;
  axi_data_t  beat_q;

  // no dequeue while a full beat waits for the sequencer
  assign yumi = fsb_valid_i && mask_i && !beat_valid_q;

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      lane_q       <= 2'd0;
      beat_valid_q <= 1'b0;
    end
    else
    begin
      if (yumi)
        lane_q <= lane_q + 2'd1;
      // take wins, packing resumes the cycle after
      if (beat_take_i)
        beat_valid_q <= 1'b0;
      else if (yumi && (lane_q == 2'(`FSB_LANES - 1)))
        beat_valid_q <= 1'b1;
    end
  end

  // packet k zero-extended into lane k
  always_ff @(posedge clk)
  begin
    if (yumi)
      beat_q[lane_q*LANE_W +: LANE_W] <= {{(LANE_W - `FSB_W){1'b0}}, fsb_data_i};
  end

  assign fsb_yumi_o   = yumi;
  assign beat_o       = beat_q;
  assign beat_valid_o = beat_valid_q;

endmodule

// File: verilog/axi_wr_sequencer.sv
// axi4 ring buffer write sequencer

`include "fsb_axi_cfg.svh"

module axi_wr_sequencer (
  input  logic                     clk,
  input  logic                     sync_rst_n,
  input  cfg_regs_pkg::wr_ctrl_t   ctrl_i,
  input  logic                     go_i,
  input  logic                     stop_i,
  input  logic                     reset_i,
  input  axi_wr_pkg::axi_data_t    beat_i,
  input  logic                     beat_valid_i,
  input  logic                     aw_ready_i,
  input  logic                     w_ready_i,
  input  logic                     b_valid_i,
  input  logic [1:0]               b_resp_i,
  output logic                     beat_take_o,
  output axi_wr_pkg::aw_chan_t     aw_o,
  output logic                     aw_valid_o,
  output axi_wr_pkg::w_chan_t      w_o,
  output logic                     w_valid_o,
  output cfg_regs_pkg::wr_status_t status_o
);
  import cfg_regs_pkg::*;
  import axi_wr_pkg::*;

  wr_state_e state_q;
  wr_state_e state_d;
  ring_off_t off_q;
  ring_off_t last_off;
  ring_off_t next_off;
  logic      tail_pend_q;
  logic      stop_pend_q;
  logic      bresp_err_q;
  logic      ring_full;
  logic      issue_tail;
  logic      issue_data;
  aw_chan_t  aw_q;
  w_chan_t   w_q;

  // ------------------------------------------------
  // ring offset and full check
  // ------------------------------------------------
  assign last_off  = ctrl_i.buf_size - ring_off_t'(`BEAT_BYTES);
  assign next_off  = (off_q == last_off) ? '0 : off_q + ring_off_t'(`BEAT_BYTES);
  // one slot kept free so head never equals the new tail
  assign ring_full = (next_off == ctrl_i.head);

  // tail goes first, then stop, then new data
  assign issue_tail = (state_q == WR_WAIT) && tail_pend_q;
  assign issue_data = (state_q == WR_WAIT) && !tail_pend_q && !stop_pend_q
                      && beat_valid_i && !ring_full;

  // ------------------------------------------------
  // write FSM
  // ------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      WR_IDLE:
        if (go_i)
          state_d = WR_WAIT;
      WR_WAIT:
        if (issue_tail || issue_data)
          state_d = WR_ADDR;
        else if (stop_pend_q)
          state_d = WR_STOP;
      WR_ADDR:
        if (aw_ready_i)
          state_d = WR_DATA;
      WR_DATA:
        if (w_ready_i)
          state_d = WR_RESP;
      WR_RESP:
        if (b_valid_i)
        begin
          // tail_pend_q still marks the write in flight
          if (stop_pend_q && tail_pend_q)
            state_d = WR_STOP;
          else
            state_d = WR_WAIT;
        end
      WR_STOP:
        if (reset_i)
          state_d = WR_IDLE;
        else if (go_i)
          state_d = WR_WAIT;
      default:
        state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      state_q <= WR_IDLE;
    else
      state_q <= state_d;
  end

  // offset moves when the data write is issued
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n || (state_q == WR_IDLE))
    begin
      off_q       <= '0;
      tail_pend_q <= 1'b0;
    end
    else
    begin
      if (issue_data)
        off_q <= next_off;
      // data and tail alternate on each response
      if ((state_q == WR_RESP) && b_valid_i)
        tail_pend_q <= !tail_pend_q;
    end
  end

  // soft stop held until idle or a new start
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n || (state_d == WR_IDLE) || go_i)
      stop_pend_q <= 1'b0;
    else if (stop_i)
      stop_pend_q <= 1'b1;
  end

  // bready is tied high, every b beat lands here
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      bresp_err_q <= 1'b0;
    else if (b_valid_i)
      bresp_err_q <= b_resp_i[1];
  end

  // ------------------------------------------------
  // aw and w payload
  // ------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (issue_tail)
    begin
      aw_q.addr  <= ctrl_i.base + axi_addr_t'(ctrl_i.buf_size);
      aw_q.len   <= 8'd0;
      // new write offset in the low word, ones above
      w_q.data   <= {{(`AXI_DATA_W - 32){1'b1}}, off_q};
      w_q.strb   <= axi_strb_t'({`TAIL_STRB_BYTES{1'b1}});
      w_q.last   <= 1'b1;
    end
    else if (issue_data)
    begin
      aw_q.addr  <= ctrl_i.base + axi_addr_t'(off_q);
      aw_q.len   <= 8'd0;
      w_q.data   <= beat_i;
      w_q.strb   <= '1;
      w_q.last   <= 1'b1;
    end
  end

  assign beat_take_o = issue_data;
  assign aw_o        = aw_q;
  assign aw_valid_o  = (state_q == WR_ADDR);
  assign w_o         = w_q;
  assign w_valid_o   = (state_q == WR_DATA);

  assign status_o.busy      = (state_q != WR_IDLE) && (state_q != WR_STOP);
  assign status_o.stop_pend = stop_pend_q;
  assign status_o.bresp_err = bresp_err_q;

endmodule

// File: verilog/fsb_axi_writer.sv
// fsb to axi4 ring buffer writer top

module fsb_axi_writer (
  input  logic                    clk,
  input  logic                    sync_rst_n,
  input  cfg_regs_pkg::cfg_req_t  cfg_req_i,
  output logic                    cfg_ack_o,
  output cfg_regs_pkg::cfg_data_t cfg_rdata_o,
  input  logic                    fsb_valid_i,
  input  axi_wr_pkg::fsb_data_t   fsb_data_i,
  output logic                    fsb_yumi_o,
  output axi_wr_pkg::aw_chan_t    aw_o,
  output logic                    aw_valid_o,
  input  logic                    aw_ready_i,
  output axi_wr_pkg::w_chan_t     w_o,
  output logic                    w_valid_o,
  input  logic                    w_ready_i,
  input  logic                    b_valid_i,
  input  logic [1:0]              b_resp_i
);
  import cfg_regs_pkg::*;
  import axi_wr_pkg::*;

  // decode to sequencer
  wr_ctrl_t   ctrl;
  wr_status_t status;
  logic       go;
  logic       stop;
  logic       soft_reset;

  // packer to sequencer
  axi_data_t  beat;
  logic       beat_valid;
  logic       beat_take;

  cfg_reg_decode cfg_reg_decode_inst (
    .clk         (clk),
    .sync_rst_n  (sync_rst_n),
    .cfg_req_i   (cfg_req_i),
    .status_i    (status),
    .cfg_ack_o   (cfg_ack_o),
    .cfg_rdata_o (cfg_rdata_o),
    .ctrl_o      (ctrl),
    .go_o        (go),
    .stop_o      (stop),
    .reset_o     (soft_reset)
  );

  fsb_beat_packer fsb_beat_packer_inst (
    .clk          (clk),
    .sync_rst_n   (sync_rst_n),
    .fsb_valid_i  (fsb_valid_i),
    .fsb_data_i   (fsb_data_i),
    .mask_i       (ctrl.wvalid_mask),
    .beat_take_i  (beat_take),
    .fsb_yumi_o   (fsb_yumi_o),
    .beat_o       (beat),
    .beat_valid_o (beat_valid)
  );

  axi_wr_sequencer axi_wr_sequencer_inst (
    .clk          (clk),
    .sync_rst_n   (sync_rst_n),
    .ctrl_i       (ctrl),
    .go_i         (go),
    .stop_i       (stop),
    .reset_i      (soft_reset),
    .beat_i       (beat),
    .beat_valid_i (beat_valid),
    .aw_ready_i   (aw_ready_i),
    .w_ready_i    (w_ready_i),
    .b_valid_i    (b_valid_i),
    .b_resp_i     (b_resp_i),
    .beat_take_o  (beat_take),
    .aw_o         (aw_o),
    .aw_valid_o   (aw_valid_o),
    .w_o          (w_o),
    .w_valid_o    (w_valid_o),
    .status_o     (status)
  );

endmodule

// File: testbench/fsb_axi_writer_assertions.sv
// axi and fsb protocol assertions

module fsb_axi_writer_assertions (
  input logic                 clk,
  input logic                 sync_rst_n,
  input logic                 aw_valid_o,
  input logic                 aw_ready_i,
  input axi_wr_pkg::aw_chan_t aw_o,
  input logic                 w_valid_o,
  input logic                 w_ready_i,
  input axi_wr_pkg::w_chan_t  w_o,
  input logic                 b_valid_i,
  input logic                 fsb_valid_i,
  input logic                 fsb_yumi_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // set on w accept, cleared by the b beat
  logic b_owed_q;

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n || b_valid_i)
      b_owed_q <= 1'b0;
    else if (w_valid_o && w_ready_i)
      b_owed_q <= 1'b1;
  end

  aw_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
    else $error("aw dropped or changed before ready");

  w_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
    else $error("w dropped or changed before ready");

  one_outstanding: assert property (@(posedge clk) disable iff (!sync_rst_n)
    aw_valid_o |-> !b_owed_q)
    else $error("aw issued while a b is outstanding");

  yumi_needs_valid: assert property (@(posedge clk) disable iff (!sync_rst_n)
    fsb_yumi_o |-> fsb_valid_i)
    else $error("yumi without valid");

endmodule

bind fsb_axi_writer fsb_axi_writer_assertions fsb_axi_writer_assertions_inst (.*);

// File: testbench/tb_fsb_axi_writer.sv
// fsb to axi writer testbench

module tb_fsb_axi_writer;
  timeunit 1ns;
  timeprecision 100ps;
  import cfg_regs_pkg::*;
  import axi_wr_pkg::*;

  typedef struct packed {
    axi_addr_t addr;
    axi_strb_t strb;
    axi_data_t data;
  } exp_t;

  logic       clk = 1'b0;
  logic       sync_rst_n;
  cfg_req_t   cfg_req_i;
  logic       cfg_ack_o;
  cfg_data_t  cfg_rdata_o;
  logic       fsb_valid_i;
  fsb_data_t  fsb_data_i;
  logic       fsb_yumi_o;
  aw_chan_t   aw_o;
  logic       aw_valid_o;
  logic       aw_ready_i;
  w_chan_t    w_o;
  logic       w_valid_o;
  logic       w_ready_i;
  logic       b_valid_i;
  logic [1:0] b_resp_i;

  integer    seed = 32'h58ce829a;
  int        err_cnt = 0;
  int        pkt_cnt = 0;
  int        aw_cnt = 0;
  int        w_cnt = 0;
  int        b_sent = 0;
  int        pkt_no = 0;
  string     test_name = "init";
  // reference model state
  axi_addr_t m_base;
  ring_off_t m_bsize;
  ring_off_t m_off;
  logic      m_tail;
  fsb_data_t pkt_q[$];
  axi_addr_t aw_addr_q[$];

  fsb_axi_writer fsb_axi_writer_inst (.*);

  always #2 clk = ~clk;

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic exp_t exp_write(input logic is_tail, input ring_off_t off,
                                     input axi_addr_t base, input ring_off_t bsize,
                                     input fsb_data_t pk[4]);
    exp_t e;
    if (is_tail)
    begin
      // tail beat carries the new offset
      e.addr = base + axi_addr_t'(bsize);
      e.strb = axi_strb_t'(64'hff);
      e.data = {{480{1'b1}}, off};
    end
    else
    begin
      e.addr = base + axi_addr_t'(off);
      e.strb = '1;
      for (int k = 0; k < 4; k++)
        e.data[k*128 +: 128] = {48'b0, pk[k]};
    end
    return e;
  endfunction

  task automatic compare_write();
    fsb_data_t pk[4];
    exp_t      e;
    axi_addr_t got_addr;
    if (!m_tail && pkt_q.size() < 4)
    begin
      $display("[ERROR] %s: data write with fewer than 4 packets taken", test_name);
      err_cnt++;
      return;
    end
    for (int k = 0; k < 4; k++)
      pk[k] = m_tail ? '0 : pkt_q.pop_front();
    e = exp_write(m_tail, m_off, m_base, m_bsize, pk);
    got_addr = (aw_addr_q.size() > 0) ? aw_addr_q.pop_front() : '1;
    if (got_addr != e.addr)
    begin
      $display("[FAIL] %s addr: exp %h got %h", test_name, e.addr, got_addr);
      err_cnt++;
    end
    if (w_o.strb != e.strb)
    begin
      $display("[FAIL] %s strb: exp %h got %h", test_name, e.strb, w_o.strb);
      err_cnt++;
    end
    if (w_o.data != e.data)
    begin
      $display("[FAIL] %s data: exp %h got %h", test_name, e.data, w_o.data);
      err_cnt++;
    end
    if (!w_o.last)
    begin
      $display("[FAIL] %s wlast: exp 1 got 0", test_name);
      err_cnt++;
    end
    // model advances, wrap at the last slot
    if (!m_tail)
      m_off = (m_off == m_bsize - 64) ? 32'd0 : m_off + 32'd64;
    m_tail = !m_tail;
  endtask

  // monitor, sampled on the rising edge
  always @(posedge clk)
  begin
    if (sync_rst_n)
    begin
      if (fsb_valid_i && fsb_yumi_o)
      begin
        pkt_q.push_back(fsb_data_i);
        pkt_cnt++;
      end
      if (aw_valid_o && aw_ready_i)
      begin
        aw_addr_q.push_back(aw_o.addr);
        aw_cnt++;
        if (aw_o.len != 8'd0)
        begin
          $display("[FAIL] %s awlen: exp 0 got %0d", test_name, aw_o.len);
          err_cnt++;
        end
      end
      if (w_valid_o && w_ready_i)
      begin
        compare_write();
        w_cnt++;
      end
    end
  end

  // --------------------------------------------------
  // axi responder, random ready, one okay b per w
  // --------------------------------------------------
  always @(negedge clk)
  begin
    if (!sync_rst_n)
    begin
      aw_ready_i = 1'b0;
      w_ready_i  = 1'b0;
      b_valid_i  = 1'b0;
    end
    else
    begin
      aw_ready_i = ($random(seed) & 3) != 0;
      w_ready_i  = ($random(seed) & 3) != 0;
      b_valid_i  = 1'b0;
      if ((b_sent < w_cnt) && ($random(seed) & 1))
      begin
        b_valid_i = 1'b1;
        b_sent++;
      end
    end
  end

  // --------------------------------------------------
  // config bus and fsb tasks
  // --------------------------------------------------
  task automatic cfg_access(input logic wr, input cfg_addr_t addr,
                            input cfg_data_t wdata, output cfg_data_t rdata);
    int cnt;
    cnt = 0;
    @(negedge clk);
    cfg_req_i = '{wr: wr, rd: !wr, addr: addr, wdata: wdata};
    @(posedge clk);
    @(negedge clk);
    cfg_req_i = '0;
    do
    begin
      @(posedge clk);
      cnt++;
    end
    while (!cfg_ack_o && cnt < 20);
    rdata = cfg_rdata_o;
    if (!cfg_ack_o)
    begin
      $display("[ERROR] %s: no config ack for offset %h", test_name, addr);
      err_cnt++;
    end
    else if (cnt != 2)
    begin
      $display("[FAIL] %s ack latency: exp 2 got %0d", test_name, cnt);
      err_cnt++;
    end
  endtask

  task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t wdata);
    cfg_data_t unused;
    cfg_access(1'b1, addr, wdata, unused);
  endtask

  task automatic check_reg(input cfg_addr_t addr, input cfg_data_t mask,
                           input cfg_data_t exp);
    cfg_data_t got;
    cfg_access(1'b0, addr, '0, got);
    if ((got & mask) != exp)
    begin
      $display("[FAIL] %s reg %h: exp %h got %h", test_name, addr, exp, got & mask);
      err_cnt++;
    end
  endtask

  // offer one packet and drop valid after it is taken
  task automatic send_packet();
    int n0;
    int t;
    n0 = pkt_cnt;
    t  = 0;
    @(negedge clk);
    fsb_valid_i = 1'b1;
    fsb_data_i  = {16'h5a00 | 16'(pkt_no), 32'(pkt_no) * 32'h9e3779b9, ~32'(pkt_no)};
    pkt_no++;
    do
    begin
      @(negedge clk);
      t++;
    end
    while (pkt_cnt == n0 && t < 500);
    fsb_valid_i = 1'b0;
    if (pkt_cnt == n0)
    begin
      $display("[ERROR] %s: packet was never taken", test_name);
      err_cnt++;
    end
  endtask

  task automatic wait_writes(input int n);
    int t;
    t = 0;
    while (w_cnt < n && t < 2000)
    begin
      @(negedge clk);
      t++;
    end
    if (w_cnt < n)
    begin
      $display("[ERROR] %s: timed out waiting for write %0d", test_name, n);
      err_cnt++;
    end
  endtask

  // every accepted w gets its b beat before moving on
  task automatic wait_bresp();
    int t;
    t = 0;
    while (b_sent < w_cnt && t < 200)
    begin
      @(negedge clk);
      t++;
    end
    if (b_sent < w_cnt)
    begin
      $display("[ERROR] %s: no write response for write %0d", test_name, w_cnt);
      err_cnt++;
    end
  endtask

  // bounded wait in which no new aw may show up
  task automatic expect_stall(input int exp_aw);
    for (int t = 0; t < 200; t++)
      @(negedge clk);
    if (aw_cnt != exp_aw)
    begin
      $display("[FAIL] %s aw count: exp %0d got %0d", test_name, exp_aw, aw_cnt);
      err_cnt++;
    end
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial
  begin
    sync_rst_n  = 1'b0;
    cfg_req_i   = '0;
    fsb_valid_i = 1'b0;
    fsb_data_i  = '0;
    aw_ready_i  = 1'b0;
    w_ready_i   = 1'b0;
    b_valid_i   = 1'b0;
    b_resp_i    = 2'b00;
    m_base  = 64'h1000;
    m_bsize = 32'd256;
    m_off   = '0;
    m_tail  = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    sync_rst_n = 1'b1;

    test_name = "registers";
    cfg_write(WADDR_LO, 32'h0000_1000);
    cfg_write(WADDR_HI, 32'ha5a5_0000);
    cfg_write(HEAD, 32'h40);
    cfg_write(BUF_SIZE, 32'd256);
    cfg_write(CFG, 32'h10);
    check_reg(WADDR_LO, '1, 32'h0000_1000);
    check_reg(WADDR_HI, '1, 32'ha5a5_0000);
    check_reg(HEAD, '1, 32'h40);
    check_reg(BUF_SIZE, '1, 32'd256);
    check_reg(CFG, '1, 32'h10);
    check_reg(8'h10, '1, 32'hffff_ffff);
    cfg_write(WADDR_HI, '0);
    cfg_write(HEAD, '0);
    cfg_write(CFG, '0);
    cfg_write(CNTL, 32'h1);
    check_reg(CNTL, 32'h1, 32'h1);

    test_name = "mask gate";
    @(negedge clk);
    fsb_valid_i = 1'b1;
    for (int t = 0; t < 20; t++)
    begin
      @(posedge clk);
      if (fsb_yumi_o)
      begin
        $display("[FAIL] %s yumi: exp 0 got 1", test_name);
        err_cnt++;
      end
    end
    @(negedge clk);
    fsb_valid_i = 1'b0;
    cfg_write(CFG, 32'h10);

    test_name = "data and tail write";
    repeat (4) send_packet();
    wait_writes(2);

    test_name = "ring fill";
    repeat (8) send_packet();
    wait_writes(6);
    repeat (4) send_packet();
    expect_stall(6);
    test_name = "ring wrap";
    cfg_write(HEAD, 32'd64);
    wait_writes(8);
    repeat (4) send_packet();
    expect_stall(8);

    test_name = "stop and reset";
    // release the waiting frame so the writer stops at a nonzero offset
    cfg_write(HEAD, 32'd128);
    wait_writes(10);
    wait_bresp();
    cfg_write(CNTL, 32'h0);
    check_reg(CNTL, 32'h3, 32'h2);
    cfg_write(RESET, 32'h1);
    check_reg(CNTL, 32'h3, 32'h0);
    m_off  = '0;
    m_tail = 1'b0;
    cfg_write(HEAD, '0);
    cfg_write(CNTL, 32'h1);
    repeat (4) send_packet();
    wait_writes(12);
    check_reg(CNTL, 32'h1, 32'h1);

    $display("checks done: %0d writes, %0d errors", w_cnt, err_cnt);
    if (err_cnt == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // run limit
  initial
  begin
    #500000;
    $display("[ERROR] simulation ran past its time limit");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: files.f
+incdir+verilog
verilog/cfg_regs_pkg.sv
verilog/axi_wr_pkg.sv
verilog/cfg_reg_decode.sv
verilog/fsb_beat_packer.sv
verilog/axi_wr_sequencer.sv
verilog/fsb_axi_writer.sv
testbench/fsb_axi_writer_assertions.sv
testbench/tb_fsb_axi_writer.sv

// File: Bender.yml
package:
  name: fsb_axi_writer

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cfg_regs_pkg.sv
      - verilog/axi_wr_pkg.sv
      - verilog/cfg_reg_decode.sv
      - verilog/fsb_beat_packer.sv
      - verilog/axi_wr_sequencer.sv
      - verilog/fsb_axi_writer.sv
  - target: test
    files:
      - testbench/fsb_axi_writer_assertions.sv
      - testbench/tb_fsb_axi_writer.sv
